// ==== include/dma_bench_checks.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma bench checks
// compare tasks for each result type and the failure helper
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DMA_BENCH_CHECKS_SVH
`define DMA_BENCH_CHECKS_SVH

task automatic fail(input string msg);
	$display("Mismatch at %0t: %s", $time, msg);
	$display("TEST FAILED");
	$fatal(1, "simulation stopped on mismatch");
endtask

task automatic check_beat(input dma_bench_pkg::rq_beat_t got, input dma_bench_pkg::rq_beat_t exp,
		input string what);
	if (got !== exp) fail($sformatf("%s beat got %h exp %h", what, got, exp));
endtask

task automatic check_desc(input dma_bench_pkg::desc_t got, input dma_bench_pkg::desc_t exp,
		input string what);
	if (got !== exp) fail($sformatf("%s desc got %h exp %h", what, got, exp));
endtask

task automatic check_stats(input dma_bench_pkg::stats_t got, input dma_bench_pkg::stats_t exp,
		input string what);
	if (got !== exp) fail($sformatf("%s stats got %h exp %h", what, got, exp));
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
	if (got !== exp) fail($sformatf("%s got %b exp %b", what, got, exp));
endtask

`endif

// ==== bench/dma_bench_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma bench testbench
// directed runs of the shim covering reset, replay styles,
// prefill hold, drain under back-pressure and statistics
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module dma_bench_tb;

	import dma_bench_pkg::*;

	`include "dma_bench_checks.svh"

	// longest run is the prefill one and stays well under 200 cycles
	localparam int RUN_CYCLES_MAX = 200;
	localparam int N_RUNS         = 4;
	localparam int TIMEOUT_CYCLES = 2 * N_RUNS * RUN_CYCLES_MAX + 400; // 2000

	logic     CLK;
	logic     RST_N;
	rq_beat_t rq_in;
	logic     rq_in_valid;
	logic     rq_in_ready;
	rq_beat_t rq_out;
	logic     rq_out_valid;
	logic     rq_out_ready;
	desc_t    desc_in;
	logic     desc_start;
	desc_t    desc_out;
	logic     engine_valid;
	logic     op_done;
	logic     final_done;
	bytes_t   bytes_in;
	logic     bytes_valid;
	stats_t   stats_out;
	logic     stats_update;

	rq_beat_t          exp_q [$];       // every beat pushed in order
	logic [ADDR_W-1:0] last_cycles;     // expected run_cycles held over beatless runs

	// owned by the output monitor
	int cyc_count     = 0;
	int rd_idx        = 0;     // next expected beat in exp_q
	int total_beats   = 0;
	int total_updates = 0;
	int first_cyc     = 0;     // cycle of the first handshake of a run
	int update_cyc    = 0;     // cycle stats_update was sampled high
	bit seen_beat     = 1'b0;

	tb_clock tb_clock_inst (
		.CLK  (CLK),
		.RST_N(RST_N)
	);

	dma_bench_top dma_bench_top_inst (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.rq_in       (rq_in),
		.rq_in_valid (rq_in_valid),
		.rq_in_ready (rq_in_ready),
		.rq_out      (rq_out),
		.rq_out_valid(rq_out_valid),
		.rq_out_ready(rq_out_ready),
		.desc_in     (desc_in),
		.desc_start  (desc_start),
		.desc_out    (desc_out),
		.engine_valid(engine_valid),
		.op_done     (op_done),
		.final_done  (final_done),
		.bytes_in    (bytes_in),
		.bytes_valid (bytes_valid),
		.stats_out   (stats_out),
		.stats_update(stats_update)
	);

	// output monitor sees the values of the cycle that just ended
	always @(posedge CLK) begin
		cyc_count = cyc_count + 1;
		if (cyc_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", cyc_count);
			$display("TEST FAILED");
			$fatal(1, "simulation stopped on timeout");
		end else begin
			if (rq_out_valid === 1'b1 && rq_out_ready === 1'b1) begin
				if (rd_idx >= exp_q.size()) begin
					fail("rq_out handshake with no beat outstanding");
				end else begin
					check_beat(rq_out, exp_q[rd_idx], "rq_out");
				end
				if (!seen_beat) begin
					first_cyc = cyc_count; // counter starts here
				end
				seen_beat   = 1'b1;
				rd_idx      = rd_idx + 1;
				total_beats = total_beats + 1;
			end
			if (stats_update === 1'b1) begin
				update_cyc    = cyc_count;
				total_updates = total_updates + 1;
				seen_beat     = 1'b0; // next handshake opens a new count
			end
		end
	end

	function automatic rq_beat_t random_beat();
		rq_beat_t    b;
		logic [63:0] u;
		logic [31:0] r;
		for (int i = 0; i < BUS_DATA_W / 32; i++) begin
			b.data[i*32 +: 32] = $urandom;
		end
		u      = {$urandom, $urandom};
		r      = $urandom;
		b.user = u[RQ_USER_W-1:0];
		b.last = r[0];
		b.keep = r[BUS_KEEP_W:1];
		return b;
	endfunction

	task automatic start_run(input desc_t d);
		@(posedge CLK);
		desc_in    <= d;
		desc_start <= 1'b1; // single cycle pulse
		@(posedge CLK);
		desc_start <= 1'b0;
		check_bit(engine_valid, 1'b0, "engine_valid while start is seen");
		@(posedge CLK);
		check_bit(engine_valid, 1'b1, "engine_valid one cycle after start");
		check_desc(desc_out, d, "desc_out at run start");
	endtask

	task automatic send_bytes(input bytes_t b);
		@(posedge CLK);
		bytes_in    <= b;
		bytes_valid <= 1'b1;
		@(posedge CLK);
		bytes_valid <= 1'b0;
	endtask

	// k-th end of operation with checks of the faked flag and the next descriptor
	task automatic pulse_done(input desc_t d, input int k);
		desc_t exp_d;
		exp_d = d;
		if (d.successive) begin
			exp_d.addr = d.addr + ADDR_W'(k) * d.size; // k windows further on
		end
		@(posedge CLK);
		op_done <= 1'b1;
		@(posedge CLK);
		op_done <= 1'b0;
		check_bit(final_done, k == N_ITERATIONS, "final_done with op_done");
		check_bit(engine_valid, 1'b1, "engine_valid during op_done");
		@(posedge CLK);
		check_desc(desc_out, exp_d, "desc_out after op_done");
		check_bit(engine_valid, k != N_ITERATIONS, "engine_valid after op_done");
		check_bit(final_done, 1'b0, "final_done without op_done");
	endtask

	task automatic run_iterations(input desc_t d);
		for (int k = 1; k <= N_ITERATIONS; k++) begin
			pulse_done(d, k);
		end
	endtask

	// back to back random beats each held until accepted
	task automatic push_beats(input int n);
		rq_beat_t b;
		for (int i = 0; i < n; i++) begin
			b = random_beat();
			exp_q.push_back(b);
			rq_in       <= b;
			rq_in_valid <= 1'b1;
			do @(posedge CLK); while (rq_in_ready !== 1'b1);
		end
		rq_in_valid <= 1'b0;
	endtask

	task automatic hold_check(input int cycles);
		repeat (cycles) begin
			@(posedge CLK);
			check_bit(rq_out_valid, 1'b0, "rq_out_valid while gate is closed");
		end
	endtask

	task automatic wait_beats(input int target);
		while (total_beats < target) @(negedge CLK);
		@(posedge CLK);
	endtask

	task automatic toggle_ready(input int target);
		logic [31:0] r;
		@(negedge CLK);
		while (total_beats < target) begin
			@(posedge CLK);
			r = $urandom;
			rq_out_ready <= r[0]; // random back-pressure
			@(negedge CLK);
		end
		@(posedge CLK);
		rq_out_ready <= 1'b1;
	endtask

	// waits for the end of run strobe and checks the reported result
	task automatic check_run_stats(input bytes_t b, input int beats, input int base_beats,
			input int base_updates);
		stats_t exp_s;
		while (total_updates == base_updates) @(negedge CLK);
		check_bit(engine_valid, 1'b0, "engine_valid at stats_update");
		check_bit(total_beats - base_beats == beats, 1'b1, "beats released in run");
		if (beats > 0) begin
			last_cycles = ADDR_W'(update_cyc - 1 - first_cyc); // first handshake to idle
		end
		exp_s.run_cycles = last_cycles;
		exp_s.bytes_req  = b.req * ADDR_W'(N_ITERATIONS);
		exp_s.bytes_comp = b.comp * ADDR_W'(N_ITERATIONS);
		check_stats(stats_out, exp_s, "stats_out at stats_update");
		check_bit(stats_out.run_cycles >= ADDR_W'(beats), 1'b1, "run_cycles vs beats");
		repeat (4) @(negedge CLK);
		check_bit(total_updates == base_updates + 1, 1'b1, "one stats_update per run");
		check_bit(rd_idx == exp_q.size(), 1'b1, "every pushed beat released");
		@(posedge CLK);
	endtask

	task automatic test_reset();
		check_bit(engine_valid, 1'b0, "engine_valid after reset");
		check_bit(rq_out_valid, 1'b0, "rq_out_valid after reset");
		check_bit(final_done, 1'b0, "final_done after reset");
		check_bit(stats_update, 1'b0, "stats_update after reset");
		check_bit(rq_in_ready, 1'b1, "rq_in_ready after reset");
	endtask

	task automatic test_same_addr();
		desc_t  d;
		bytes_t b;
		int     base_b;
		int     base_u;
		d.addr       = 64'h0000_0040_0000_1000;
		d.size       = 64'h0000_0000_0000_0200;
		d.successive = 1'b0;
		b.req        = 64'd512;
		b.comp       = 64'd512;
		base_b       = total_beats;
		base_u       = total_updates;
		start_run(d);
		send_bytes(b);
		run_iterations(d);
		check_run_stats(b, 0, base_b, base_u);
	endtask

	task automatic test_successive();
		desc_t  d;
		bytes_t b;
		int     base_b;
		int     base_u;
		d.addr       = 64'h0000_0000_8000_0000;
		d.size       = 64'h0000_0000_0000_1000;
		d.successive = 1'b1;
		b.req        = {32'h0, $urandom};
		b.comp       = {32'h0, $urandom};
		base_b       = total_beats;
		base_u       = total_updates;
		start_run(d);
		send_bytes(b);
		run_iterations(d);
		check_run_stats(b, 0, base_b, base_u);
	endtask

	task automatic test_prefill();
		desc_t  d;
		bytes_t b;
		int     base_b;
		int     base_u;
		d.addr       = 64'h0000_0001_0000_0000;
		d.size       = 64'h0000_0000_0000_0800;
		d.successive = 1'b1;
		b.req        = {32'h0, $urandom};
		b.comp       = {32'h0, $urandom};
		base_b       = total_beats;
		base_u       = total_updates;
		start_run(d);
		send_bytes(b);
		push_beats(PREFILL_BEATS - 1);
		hold_check(6);                         // one short of the threshold
		push_beats(1);
		wait_beats(base_b + PREFILL_BEATS);
		run_iterations(d);
		check_run_stats(b, PREFILL_BEATS, base_b, base_u);
	endtask

	task automatic test_drain();
		desc_t  d;
		bytes_t b;
		int     base_b;
		int     base_u;
		d.addr       = 64'h0000_0002_0000_4000;
		d.size       = 64'h0000_0000_0000_0100;
		d.successive = 1'b0;
		b.req        = {32'h0, $urandom};
		b.comp       = {32'h0, $urandom};
		base_b       = total_beats;
		base_u       = total_updates;
		start_run(d);
		send_bytes(b);
		push_beats(5);
		hold_check(4);
		fork
			toggle_ready(base_b + 5);          // beats only leave once draining
			run_iterations(d);
		join
		check_run_stats(b, 5, base_b, base_u);
	endtask

	initial begin
		rq_in        <= '0;
		rq_in_valid  <= 1'b0;
		rq_out_ready <= 1'b1;
		desc_in      <= '0;
		desc_start   <= 1'b0;
		op_done      <= 1'b0;
		bytes_in     <= '0;
		bytes_valid  <= 1'b0;
		last_cycles   = '0;    // counter value out of reset
		void'($urandom(18));
		while (RST_N !== 1'b1) @(posedge CLK);
		test_reset();
		test_same_addr();
		test_successive();
		test_prefill();
		test_drain();
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== bench/tb_clock.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock
// 100 ns clock, reset held low for the first 3 edges
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_clock (
	output logic CLK,
	output logic RST_N
);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK; // half period
	end

	initial begin
		RST_N <= 1'b0;
		repeat (3) @(posedge CLK);
		RST_N <= 1'b1; // released after the third edge
	end

endmodule

// ==== dma_bench.f ====
+incdir+include
src/dma_bench_pkg.sv
src/rq_fifo.sv
src/rq_release.sv
src/descriptor_replay.sv
src/bench_stats.sv
src/dma_bench_top.sv
bench/tb_clock.sv
bench/dma_bench_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the DMA bench testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module dma_bench_tb -f dma_bench.f -o dma_bench_sim &&
out=$(./obj_dir/dma_bench_sim)
echo "$out"
echo "$out" | grep -q "TEST OK" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== src/bench_stats.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bench statistics
// run cycle count, scaled byte counts, update strobe
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module bench_stats (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  first_out,
	input  logic                  idle,
	input  dma_bench_pkg::bytes_t bytes_in,
	input  logic                  bytes_valid,
	output dma_bench_pkg::stats_t stats_out,
	output logic                  stats_update
);

	import dma_bench_pkg::*;

	logic [ADDR_W-1:0] cycles_r;     // run latency
	logic              counting_r;
	logic              idle_p_r;     // idle one cycle ago
	logic              idle_rise;    // back in idle this cycle
	logic              update_r;
	logic [ADDR_W-1:0] bytes_req_r;
	logic [ADDR_W-1:0] bytes_comp_r;

	assign idle_rise = idle && !idle_p_r;

	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			cycles_r   <= '0;
			counting_r <= 1'b0;
			idle_p_r   <= 1'b1; // no strobe out of reset
			update_r   <= 1'b0;
		end else begin
			idle_p_r <= idle;
			update_r <= idle_rise; // counter is frozen by then
			if (idle_rise) begin
				counting_r <= 1'b0;
			end else if (counting_r) begin
				cycles_r <= cycles_r + 1'b1;
			end else if (first_out) begin
				counting_r <= 1'b1;
				cycles_r   <= ADDR_W'(1); // previous result cleared here
			end
		end
	end

	// engine reports one replay, scale to the whole run
	always_ff @(posedge CLK) begin
		if (bytes_valid) begin
			bytes_req_r  <= bytes_in.req * ADDR_W'(N_ITERATIONS);
			bytes_comp_r <= bytes_in.comp * ADDR_W'(N_ITERATIONS);
		end
	end

	always_comb begin
		stats_out.run_cycles = cycles_r;
		stats_out.bytes_req  = bytes_req_r;
		stats_out.bytes_comp = bytes_comp_r;
	end

	assign stats_update = update_r;

endmodule

// ==== src/descriptor_replay.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// descriptor replay
// replays one user descriptor N_ITERATIONS times and fakes
// the end-of-operation flag on the final pass only
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module descriptor_replay (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  dma_bench_pkg::desc_t desc_in,
	input  logic                 desc_start,
	input  logic                 op_done,
	input  logic                 empty,
	output dma_bench_pkg::desc_t desc_out,
	output logic                 engine_valid,
	output logic                 final_done,
	output logic                 drain,
	output logic                 idle
);

	import dma_bench_pkg::*;

	typedef enum logic [1:0] {
		IDLE  = 2'd0, // waiting for the user descriptor
		RUN   = 2'd1, // engine replaying
		DRAIN = 2'd2  // iterations done, fifo emptying
	} state_t;

	state_t            state_r;
	logic [ADDR_W-1:0] iter_r;       // current iteration, counts from 1
	logic              valid_r;      // faked engine valid
	logic              last_iter;
	desc_t             user_r;       // descriptor as given by the user
	desc_t             desc_r;       // descriptor presented to the engine

	assign last_iter = (iter_r == ADDR_W'(N_ITERATIONS));

	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			state_r <= IDLE;
			iter_r  <= ADDR_W'(1);
			valid_r <= 1'b0;
		end else begin
			case (state_r)
				IDLE: begin
					iter_r <= ADDR_W'(1);
					if (desc_start) begin
						state_r <= RUN;
						valid_r <= 1'b1; // one cycle after start
					end
				end
				RUN: begin
					if (op_done) begin
						iter_r <= iter_r + 1'b1;
						if (last_iter) begin
							state_r <= DRAIN;
							valid_r <= 1'b0;
						end
					end
				end
				DRAIN: begin
					if (empty) begin
						state_r <= IDLE; // nothing left to send
					end
				end
				default: begin
					state_r <= IDLE;
					valid_r <= 1'b0;
				end
			endcase
		end
	end

	// descriptor payload
	always_ff @(posedge CLK) begin
		if (state_r == IDLE) begin
			user_r <= desc_in; // track the user until the run starts
			desc_r <= desc_in;
		end else if (state_r == RUN && op_done) begin
			if (user_r.successive) begin
				desc_r.addr <= desc_r.addr + desc_r.size; // next window
			end else begin
				desc_r.addr <= user_r.addr; // same area every pass
			end
			desc_r.size <= user_r.size;
		end
	end

	assign desc_out     = desc_r;
	assign engine_valid = valid_r;
	// end of operation is only seen by the host on the final pass
	assign final_done   = op_done && (state_r == RUN) && last_iter;
	assign drain        = (state_r == DRAIN);
	assign idle         = (state_r == IDLE);

endmodule

// ==== src/dma_bench_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma bench package
// widths, depths and the iteration count of the DMA benchmarking shim,
// together with the packed structs shared by the RTL and the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dma_bench_pkg;

	// request stream geometry
	localparam int BUS_DATA_W = 256;             // rq data width
	localparam int BUS_KEEP_W = BUS_DATA_W / 32; // one keep bit per dword
	localparam int RQ_USER_W  = 60;              // rq user sideband

	// descriptor and counters
	localparam int ADDR_W = 64; // address, size and counter width

	// replay
	localparam int N_ITERATIONS = 4; // descriptor replays per run

	// request buffering
	localparam int FIFO_DEPTH    = 64;                     // beats
	localparam int PREFILL_BEATS = 16;                     // level that opens the gate
	localparam int FIFO_LEVEL_W  = $clog2(FIFO_DEPTH) + 1; // holds 0..FIFO_DEPTH

	// one request beat, 325 bits
	typedef struct packed {
		logic [BUS_DATA_W-1:0] data; // tlp payload
		logic [RQ_USER_W-1:0]  user; // rq sideband
		logic                  last; // end of tlp
		logic [BUS_KEEP_W-1:0] keep; // dword enables
	} rq_beat_t;

	// descriptor as seen by the engine, 129 bits
	typedef struct packed {
		logic [ADDR_W-1:0] addr;       // host address
		logic [ADDR_W-1:0] size;       // transfer size in bytes
		logic              successive; // 1: advance addr by size on each replay
	} desc_t;

	// byte report from the engine
	typedef struct packed {
		logic [ADDR_W-1:0] req;  // bytes requested
		logic [ADDR_W-1:0] comp; // bytes completed
	} bytes_t;

	// run result, 192 bits
	typedef struct packed {
		logic [ADDR_W-1:0] run_cycles; // first release to idle
		logic [ADDR_W-1:0] bytes_req;  // scaled by N_ITERATIONS
		logic [ADDR_W-1:0] bytes_comp; // scaled by N_ITERATIONS
	} stats_t;

endpackage

// ==== src/dma_bench_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma bench top
// benchmarking shim between the DMA engine and the PCIe rq port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module dma_bench_top (
	input  logic                    CLK,
	input  logic                    RST_N,
	// request stream from the engine
	input  dma_bench_pkg::rq_beat_t rq_in,
	input  logic                    rq_in_valid,
	output logic                    rq_in_ready,
	// request stream to PCIe
	output dma_bench_pkg::rq_beat_t rq_out,
	output logic                    rq_out_valid,
	input  logic                    rq_out_ready,
	// user descriptor and faked descriptor
	input  dma_bench_pkg::desc_t    desc_in,
	input  logic                    desc_start,
	output dma_bench_pkg::desc_t    desc_out,
	output logic                    engine_valid,
	// end of operation
	input  logic                    op_done,
	output logic                    final_done,
	// statistics
	input  dma_bench_pkg::bytes_t   bytes_in,
	input  logic                    bytes_valid,
	output dma_bench_pkg::stats_t   stats_out,
	output logic                    stats_update
);

	import dma_bench_pkg::*;

	logic                    fifo_full;
	logic                    fifo_wr;
	logic                    fifo_pop;
	logic [FIFO_LEVEL_W-1:0] fifo_level;
	rq_beat_t                fifo_head;
	logic                    drain;
	logic                    empty;
	logic                    idle;
	logic                    first_out;

	assign rq_in_ready = !fifo_full;
	assign fifo_wr     = rq_in_valid && !fifo_full; // input handshake

	rq_fifo #(
		.payload_t(rq_beat_t)
	) rq_fifo_inst (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.wr_data(rq_in),
		.wr_en  (fifo_wr),
		.rd_en  (fifo_pop),
		.rd_data(fifo_head),
		.full   (fifo_full),
		.level  (fifo_level)
	);

	rq_release rq_release_inst (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.level       (fifo_level),
		.head        (fifo_head),
		.drain       (drain),
		.pop         (fifo_pop),
		.rq_out      (rq_out),
		.rq_out_valid(rq_out_valid),
		.rq_out_ready(rq_out_ready),
		.empty       (empty),
		.first_out   (first_out)
	);

	descriptor_replay descriptor_replay_inst (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.desc_in     (desc_in),
		.desc_start  (desc_start),
		.op_done     (op_done),
		.empty       (empty),
		.desc_out    (desc_out),
		.engine_valid(engine_valid),
		.final_done  (final_done),
		.drain       (drain),
		.idle        (idle)
	);

	bench_stats bench_stats_inst (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.first_out   (first_out),
		.idle        (idle),
		.bytes_in    (bytes_in),
		.bytes_valid (bytes_valid),
		.stats_out   (stats_out),
		.stats_update(stats_update)
	);

endmodule

// ==== src/rq_fifo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request FIFO
// circular buffer with an occupancy count for any payload type
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rq_fifo #(
	parameter type payload_t = dma_bench_pkg::rq_beat_t
) (
	input  logic                                  CLK,
	input  logic                                  RST_N,
	input  payload_t                              wr_data,
	input  logic                                  wr_en,
	input  logic                                  rd_en,
	output payload_t                              rd_data,
	output logic                                  full,
	output logic [dma_bench_pkg::FIFO_LEVEL_W-1:0] level
);

	import dma_bench_pkg::*;

	payload_t                  mem [FIFO_DEPTH]; // beat storage
	logic [FIFO_LEVEL_W-2:0]   wr_ptr_r;         // wraps at FIFO_DEPTH
	logic [FIFO_LEVEL_W-2:0]   rd_ptr_r;
	logic [FIFO_LEVEL_W-1:0]   level_r;          // one bit wider than the pointers

	// storage array
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_ptr_r] <= wr_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			level_r  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr_r <= wr_ptr_r + 1'b1; // natural wrap at the power of two depth
			end
			if (rd_en) begin
				rd_ptr_r <= rd_ptr_r + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   level_r <= level_r + 1'b1;
				2'b01:   level_r <= level_r - 1'b1;
				default: level_r <= level_r; // both or neither
			endcase
		end
	end

	assign rd_data = mem[rd_ptr_r]; // head is combinational
	assign full    = (level_r == FIFO_LEVEL_W'(FIFO_DEPTH));
	assign level   = level_r;

endmodule

// ==== src/rq_release.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request release
// prefill gate and one-beat registered output stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rq_release (
	input  logic                                  CLK,
	input  logic                                  RST_N,
	input  logic [dma_bench_pkg::FIFO_LEVEL_W-1:0] level,
	input  dma_bench_pkg::rq_beat_t               head,
	input  logic                                  drain,
	output logic                                  pop,
	output dma_bench_pkg::rq_beat_t               rq_out,
	output logic                                  rq_out_valid,
	input  logic                                  rq_out_ready,
	output logic                                  empty,
	output logic                                  first_out
);

	import dma_bench_pkg::*;

	logic     primed_r;  // threshold was reached in this run
	logic     gate_open; // beats may leave the fifo
	logic     stage_free;
	logic     valid_r;
	rq_beat_t beat_r;    // output stage payload

	// once prefilled the gate stays open, so a level dipping below the
	// threshold does not stall the stream mid run
	assign gate_open  = primed_r || (level >= FIFO_LEVEL_W'(PREFILL_BEATS)) || drain;
	assign stage_free = !valid_r || rq_out_ready; // empty or emptied this cycle
	assign pop        = stage_free && gate_open && (level != '0);

	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			primed_r <= 1'b0;
			valid_r  <= 1'b0;
		end else begin
			if (drain && empty) begin
				primed_r <= 1'b0; // run fully sent, rearm for the next one
			end else if (level >= FIFO_LEVEL_W'(PREFILL_BEATS)) begin
				primed_r <= 1'b1;
			end
			if (pop) begin
				valid_r <= 1'b1;
			end else if (rq_out_ready) begin
				valid_r <= 1'b0; // handshake done, nothing to refill with
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (pop) begin
			beat_r <= head; // holds while ready is low
		end
	end

	assign rq_out       = beat_r;
	assign rq_out_valid = valid_r;
	assign empty        = (level == '0) && !valid_r; // fifo and stage both drained
	assign first_out    = valid_r && rq_out_ready;   // every output handshake

endmodule
